/* include/fetch_consts.svh */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// empty pipeline slot markers
`define REGPC_NOP 32'hffff_fffc
`define INST_NOP 32'h0000_0013

`define RESET_PC 32'h0000_0000

// instruction RAM geometry and timing
`define IMEM_WORDS 256
`define IMEM_ADDR_W $clog2(`IMEM_WORDS)
`define IMEM_LATENCY 3

`endif

/* hw/core_pkg.sv */
package core_pkg;

	typedef enum logic {
		fetch_wait_ready,
		fetch_wait_valid
	} fetch_state_t;

	// RV32I major opcodes, bits 6:0 of the instruction
	typedef enum logic [6:0] {
		op_lui     = 7'b0110111,
		op_auipc   = 7'b0010111,
		op_jal     = 7'b1101111,
		op_jalr    = 7'b1100111,
		op_branch  = 7'b1100011,
		op_load    = 7'b0000011,
		op_store   = 7'b0100011,
		op_imm     = 7'b0010011,
		op_reg     = 7'b0110011,
		op_illegal = 7'b0000000 // no rv32i opcode uses all zeros
	} opcode_t;

endpackage

/* hw/mem_pkg.sv */
package mem_pkg;

	typedef enum logic {
		mem_idle,
		mem_busy
	} mem_state_t;

endpackage

/* hw/fetch_stage.sv */
`include "fetch_consts.svh"

module fetch_stage (
	input  logic        clk,
	input  logic        reset,
	input  logic        redirect,
	input  logic [31:0] redirect_pc,
	input  logic        stall,
	input  logic        mem_ready,
	input  logic [31:0] mem_data,
	input  logic        mem_data_valid,
	output logic        mem_start,
	output logic [31:0] mem_addr,
	output logic [31:0] id_reg_pc,
	output logic [31:0] id_inst
);
	import core_pkg::*;

	fetch_state_t state;
	logic [31:0] pc; // address of the outstanding request
	logic fetched; // save slot holds a word
	logic [31:0] saved_pc;
	logic [31:0] saved_inst;

	logic word_here;
	logic advance;
	logic save_word;
	logic [31:0] req_addr;

	// fresh word from memory, not yet taken
	assign word_here = (state == fetch_wait_valid) && !fetched && mem_data_valid;

	// current slot is done with, either consumed or flushed
	assign advance = (state == fetch_wait_valid) &&
		(redirect || (!stall && (word_here || fetched)));

	assign save_word = word_here && stall && !redirect;

	always_comb begin
		if (state == fetch_wait_ready)
			mem_start = mem_ready;
		else
			mem_start = advance && !stall && mem_ready;
	end

	always_comb begin
		if (redirect)
			req_addr = redirect_pc;
		else if (word_here)
			req_addr = pc + 32'd4; // pc still points at the returning word
		else
			req_addr = pc;
	end

	assign mem_addr = mem_start ? req_addr : `REGPC_NOP;

	always_comb begin
		if (stall || redirect) begin
			id_reg_pc = `REGPC_NOP;
			id_inst = `INST_NOP;
		end else if (word_here) begin
			id_reg_pc = pc;
			id_inst = mem_data;
		end else if (state == fetch_wait_valid && fetched) begin
			id_reg_pc = saved_pc;
			id_inst = saved_inst;
		end else begin
			id_reg_pc = `REGPC_NOP;
			id_inst = `INST_NOP;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= fetch_wait_ready;
			pc <= `RESET_PC;
			fetched <= 1'b0;
		end else if (state == fetch_wait_ready) begin
			if (redirect)
				pc <= redirect_pc;
			if (mem_ready) begin
				state <= fetch_wait_valid;
				fetched <= 1'b0;
			end
		end else begin
			if (redirect)
				pc <= redirect_pc;
			else if (word_here)
				pc <= pc + 32'd4;

			if (advance) begin
				fetched <= 1'b0;
				// nothing in flight now, wait for memory to come back
				if (!mem_start)
					state <= fetch_wait_ready;
			end else if (save_word) begin
				fetched <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (save_word) begin
			saved_pc <= pc;
			saved_inst <= mem_data;
		end
	end

endmodule

/* hw/inst_memory.sv */
`include "fetch_consts.svh"

module inst_memory (
	input  logic        clk,
	input  logic        reset,
	input  logic        mem_start,
	input  logic [31:0] mem_addr,
	input  logic        prog_we,
	input  logic [31:0] prog_addr,
	input  logic [31:0] prog_data,
	output logic        mem_ready,
	output logic [31:0] mem_data,
	output logic        mem_data_valid
);
	import mem_pkg::*;

	typedef logic [$clog2(`IMEM_LATENCY + 1)-1:0] lat_cnt_t;

	logic [31:0] mem_array [`IMEM_WORDS];

	mem_state_t state;
	lat_cnt_t lat_cnt; // cycles left before data_valid
	logic [31:0] data_q;

	// program load, word addressed
	always_ff @(posedge clk) begin
		if (prog_we)
			mem_array[prog_addr[`IMEM_ADDR_W+1:2]] <= prog_data;
	end

	assign mem_data_valid = (state == mem_busy) && (lat_cnt == '0);
	assign mem_ready = (state == mem_idle) || mem_data_valid; // back to back
	assign mem_data = data_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= mem_idle;
			lat_cnt <= '0;
		end else if (mem_start && mem_ready) begin
			state <= mem_busy;
			lat_cnt <= lat_cnt_t'(`IMEM_LATENCY - 1);
		end else if (state == mem_busy) begin
			if (lat_cnt == '0)
				state <= mem_idle;
			else
				lat_cnt <= lat_cnt - lat_cnt_t'(1);
		end
	end

	// word is read at start and held until the valid pulse
	always_ff @(posedge clk) begin
		if (mem_start && mem_ready)
			data_q <= mem_array[mem_addr[`IMEM_ADDR_W+1:2]];
	end

endmodule

/* hw/decode_stage.sv */
`include "fetch_consts.svh"

module decode_stage (
	input  logic              clk,
	input  logic              reset,
	input  logic [31:0]       id_reg_pc,
	input  logic [31:0]       id_inst,
	output logic              dec_valid,
	output logic [31:0]       dec_pc,
	output core_pkg::opcode_t dec_opcode,
	output logic [4:0]        dec_rd,
	output logic [31:0]       dec_imm
);
	import core_pkg::*;

	logic slot_valid;
	opcode_t opcode;
	logic [31:0] imm;

	assign slot_valid = (id_reg_pc != `REGPC_NOP);

	always_comb begin
		case (id_inst[6:0])
			op_lui, op_auipc, op_jal, op_jalr, op_branch,
			op_load, op_store, op_imm, op_reg:
				opcode = opcode_t'(id_inst[6:0]);
			default:
				opcode = op_illegal;
		endcase
	end

	always_comb begin
		case (opcode)
			op_imm, op_load, op_jalr: // i-type
				imm = {{20{id_inst[31]}}, id_inst[31:20]};
			op_store:
				imm = {{20{id_inst[31]}}, id_inst[31:25], id_inst[11:7]};
			op_branch:
				imm = {{19{id_inst[31]}}, id_inst[31], id_inst[7],
					id_inst[30:25], id_inst[11:8], 1'b0};
			op_lui, op_auipc:
				imm = {id_inst[31:12], 12'b0};
			op_jal:
				imm = {{11{id_inst[31]}}, id_inst[31], id_inst[19:12],
					id_inst[20], id_inst[30:21], 1'b0};
			default:
				imm = 32'd0; // r-type and illegal
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			dec_valid <= 1'b0;
		else
			dec_valid <= slot_valid;
	end

	// payload only moves on a real instruction
	always_ff @(posedge clk) begin
		if (slot_valid) begin
			dec_pc <= id_reg_pc;
			dec_opcode <= opcode;
			dec_rd <= id_inst[11:7];
			dec_imm <= imm;
		end
	end

endmodule

/* hw/fetch_top.sv */
module fetch_top (
	input  logic              clk,
	input  logic              reset,
	input  logic              stall,
	input  logic              redirect,
	input  logic [31:0]       redirect_pc,
	input  logic              prog_we,
	input  logic [31:0]       prog_addr,
	input  logic [31:0]       prog_data,
	output logic              dec_valid,
	output logic [31:0]       dec_pc,
	output core_pkg::opcode_t dec_opcode,
	output logic [4:0]        dec_rd,
	output logic [31:0]       dec_imm
);

	logic mem_start;
	logic [31:0] mem_addr;
	logic mem_ready;
	logic [31:0] mem_data;
	logic mem_data_valid;

	logic [31:0] id_reg_pc;
	logic [31:0] id_inst;

	fetch_stage u_fetch_stage (
		.clk            (clk),
		.reset          (reset),
		.redirect       (redirect),
		.redirect_pc    (redirect_pc),
		.stall          (stall),
		.mem_ready      (mem_ready),
		.mem_data       (mem_data),
		.mem_data_valid (mem_data_valid),
		.mem_start      (mem_start),
		.mem_addr       (mem_addr),
		.id_reg_pc      (id_reg_pc),
		.id_inst        (id_inst)
	);

	inst_memory u_inst_memory (
		.clk            (clk),
		.reset          (reset),
		.mem_start      (mem_start),
		.mem_addr       (mem_addr),
		.prog_we        (prog_we),
		.prog_addr      (prog_addr),
		.prog_data      (prog_data),
		.mem_ready      (mem_ready),
		.mem_data       (mem_data),
		.mem_data_valid (mem_data_valid)
	);

	decode_stage u_decode_stage (
		.clk        (clk),
		.reset      (reset),
		.id_reg_pc  (id_reg_pc),
		.id_inst    (id_inst),
		.dec_valid  (dec_valid),
		.dec_pc     (dec_pc),
		.dec_opcode (dec_opcode),
		.dec_rd     (dec_rd),
		.dec_imm    (dec_imm)
	);

endmodule

/* tests/tb_fetch_top.sv */
`include "fetch_consts.svh"

module tb_fetch_top;
	timeunit 1ns;
	timeprecision 1ps;

	import core_pkg::*;

	localparam int CLK_PERIOD = 10;
	localparam int NUM_TESTS = 6;
	localparam int PROG_WORDS = 32;
	localparam int FORMAT_WORDS = 11; // nine classes and two undefined opcodes
	localparam int EVENT_LIMIT = 40; // cycles allowed for one instruction

	logic clk;
	logic reset;
	logic stall;
	logic redirect;
	logic [31:0] redirect_pc;
	logic prog_we;
	logic [31:0] prog_addr;
	logic [31:0] prog_data;
	logic dec_valid;
	logic [31:0] dec_pc;
	opcode_t dec_opcode;
	logic [4:0] dec_rd;
	logic [31:0] dec_imm;

	logic [31:0] image [PROG_WORDS]; // words loaded into the DUT
	logic [31:0] lcg_state = 32'ha61a_7e89;
	int mismatches = 0;
	int failures = 0;

	fetch_top u_fetch_top (
		.clk         (clk),
		.reset       (reset),
		.stall       (stall),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.prog_we     (prog_we),
		.prog_addr   (prog_addr),
		.prog_data   (prog_data),
		.dec_valid   (dec_valid),
		.dec_pc      (dec_pc),
		.dec_opcode  (dec_opcode),
		.dec_rd      (dec_rd),
		.dec_imm     (dec_imm)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(NUM_TESTS * 200 * CLK_PERIOD);
		$display("timeout: the tests did not finish in time");
		$display("TEST FAILED");
		$finish;
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [6:0] class_bits(int k);
		case (k)
			0: return 7'b0110111; // lui
			1: return 7'b0010111; // auipc
			2: return 7'b1101111; // jal
			3: return 7'b1100111; // jalr
			4: return 7'b1100011; // branch
			5: return 7'b0000011; // load
			6: return 7'b0100011; // store
			7: return 7'b0010011; // op-imm
			8: return 7'b0110011; // op
			9: return 7'b0001111; // fence, not in the list
			default: return 7'b1111111;
		endcase
	endfunction

	function automatic opcode_t ref_opcode(logic [31:0] w);
		case (w[6:0])
			7'b0110111: return op_lui;
			7'b0010111: return op_auipc;
			7'b1101111: return op_jal;
			7'b1100111: return op_jalr;
			7'b1100011: return op_branch;
			7'b0000011: return op_load;
			7'b0100011: return op_store;
			7'b0010011: return op_imm;
			7'b0110011: return op_reg;
			default: return op_illegal;
		endcase
	endfunction

	function automatic logic [31:0] ref_imm(logic [31:0] w);
		case (ref_opcode(w))
			op_imm, op_load, op_jalr: return $signed(w) >>> 20;
			op_store: return {{20{w[31]}}, w[31:25], w[11:7]};
			op_branch: return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
			op_lui, op_auipc: return w & 32'hffff_f000;
			op_jal: return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
			default: return 32'd0;
		endcase
	endfunction

	task automatic note_failure(string what);
		$display("error: %s", what);
		failures++;
	endtask

	task automatic check_word(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_opcode(string name, opcode_t got, opcode_t exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_rd(string name, logic [4:0] got, logic [4:0] exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			mismatches++;
		end
	endtask

	// random words forced to a chosen opcode class
	task automatic fill_program(bit in_order);
		int i;
		int k;
		logic [31:0] r;
		for (i = 0; i < PROG_WORDS; i++) begin
			r = next_rand();
			k = in_order ? i % FORMAT_WORDS : int'((next_rand() >> 16) % 11);
			image[i] = {r[31:7], class_bits(k)};
		end
	endtask

	// load the program under reset, then 8 more reset cycles
	task automatic restart_dut(bit in_order);
		int i;
		fill_program(in_order);
		@(posedge clk);
		reset <= 1'b1;
		stall <= 1'b0;
		redirect <= 1'b0;
		for (i = 0; i < PROG_WORDS; i++) begin
			@(posedge clk);
			prog_we <= 1'b1;
			prog_addr <= 32'(i) << 2;
			prog_data <= image[i];
		end
		@(posedge clk);
		prog_we <= 1'b0;
		for (i = 0; i < 8; i++) begin
			@(negedge clk);
			if (dec_valid !== 1'b0)
				note_failure("dec_valid was high during reset");
			@(posedge clk);
		end
		reset <= 1'b0;
	endtask

	task automatic wait_event(output bit seen);
		int n;
		n = 0;
		@(negedge clk);
		while (dec_valid !== 1'b1 && n < EVENT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		seen = (dec_valid === 1'b1);
		if (!seen)
			note_failure("no instruction reached decode in time");
	endtask

	task automatic expect_instr(logic [31:0] pc);
		logic [31:0] w;
		w = image[pc[6:2]];
		check_word("dec_pc", dec_pc, pc);
		check_opcode("dec_opcode", dec_opcode, ref_opcode(w));
		check_rd("dec_rd", dec_rd, w[11:7]);
		check_word("dec_imm", dec_imm, ref_imm(w));
	endtask

	task automatic reset_behavior();
		bit seen;
		restart_dut(1'b0);
		@(negedge clk);
		@(negedge clk); // first slot sampled with reset low
		if (dec_valid !== 1'b0)
			note_failure("dec_valid was high right after reset");
		wait_event(seen);
		if (seen)
			expect_instr(`RESET_PC);
	endtask

	task automatic sequential_fetch();
		int i;
		bit seen;
		logic [31:0] pc;
		restart_dut(1'b0);
		pc = `RESET_PC;
		for (i = 0; i < 20; i++) begin
			wait_event(seen);
			if (!seen)
				break;
			expect_instr(pc);
			pc += 32'd4;
		end
	endtask

	task automatic stall_backpressure();
		int got;
		int left;
		int cycles;
		bit stall_now;
		bit stall_was;
		logic [31:0] pc;
		restart_dut(1'b0);
		pc = `RESET_PC;
		got = 0;
		left = 0;
		cycles = 0;
		stall_now = 1'b0;
		while (got < 12 && cycles < 160) begin
			@(posedge clk);
			stall_was = stall_now;
			if (left == 0 && (next_rand() >> 16) % 5 == 0)
				left = 1 + int'((next_rand() >> 16) % 10); // 1 to 10 cycles
			stall_now = (left > 0);
			if (left > 0)
				left--;
			stall <= stall_now;
			@(negedge clk);
			cycles++;
			// dec_valid reflects the previous cycle's slot
			if (stall_was && dec_valid)
				note_failure("an instruction reached decode while stalled");
			if (dec_valid) begin
				expect_instr(pc);
				pc += 32'd4;
				got++;
			end
		end
		@(posedge clk);
		stall <= 1'b0;
		if (got < 12)
			note_failure("too few instructions got through the stall test");
	endtask

	task automatic redirect_pulse();
		int i;
		int delay;
		bit seen;
		logic [31:0] pc;
		logic [31:0] target;
		restart_dut(1'b0);
		pc = `RESET_PC;
		for (i = 0; i < 3; i++) begin
			wait_event(seen);
			if (!seen)
				return;
			expect_instr(pc);
			pc += 32'd4;
		end
		target = (32'd8 + (next_rand() >> 16) % 32'd16) << 2;
		delay = int'((next_rand() >> 16) % 3); // hit idle and busy memory
		repeat (delay) @(posedge clk);
		@(posedge clk);
		redirect <= 1'b1;
		redirect_pc <= target;
		@(negedge clk);
		if (dec_valid)
			expect_instr(pc); // still the old path, in order
		@(posedge clk);
		redirect <= 1'b0;
		pc = target;
		for (i = 0; i < 4; i++) begin
			wait_event(seen);
			if (!seen)
				return;
			expect_instr(pc);
			pc += 32'd4;
		end
	endtask

	task automatic decode_formats();
		int i;
		bit seen;
		logic [31:0] pc;
		restart_dut(1'b1);
		pc = `RESET_PC;
		for (i = 0; i < FORMAT_WORDS; i++) begin
			wait_event(seen);
			if (!seen)
				break;
			expect_instr(pc);
			if (i >= 9)
				check_opcode("dec_opcode", dec_opcode, op_illegal);
			pc += 32'd4;
		end
	endtask

	task automatic redirect_during_stall();
		int i;
		bit seen;
		logic [31:0] pc;
		logic [31:0] target;
		restart_dut(1'b0);
		pc = `RESET_PC;
		target = 32'h0000_0060;
		for (i = 0; i < 2; i++) begin
			wait_event(seen);
			if (!seen)
				return;
			expect_instr(pc);
			pc += 32'd4;
		end
		// long enough for the next word to land in the save slot
		for (i = 0; i < 6; i++) begin
			@(posedge clk);
			stall <= 1'b1;
			if (i == 5) begin
				redirect <= 1'b1;
				redirect_pc <= target;
			end
			@(negedge clk);
			if (i > 0 && dec_valid)
				note_failure("an instruction reached decode while stalled");
		end
		@(posedge clk);
		stall <= 1'b0;
		redirect <= 1'b0;
		pc = target;
		for (i = 0; i < 3; i++) begin
			wait_event(seen);
			if (!seen)
				return;
			expect_instr(pc);
			pc += 32'd4;
		end
	endtask

	initial begin
		reset = 1'b1;
		stall = 1'b0;
		redirect = 1'b0;
		redirect_pc = 32'd0;
		prog_we = 1'b0;
		prog_addr = 32'd0;
		prog_data = 32'd0;

		reset_behavior();
		sequential_fetch();
		stall_backpressure();
		redirect_pulse();
		decode_formats();
		redirect_during_stall();

		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+include
hw/core_pkg.sv
hw/mem_pkg.sv
hw/fetch_stage.sv
hw/inst_memory.sv
hw/decode_stage.sv
hw/fetch_top.sv
tests/tb_fetch_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the fetch front end testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
	--top-module tb_fetch_top \
	-f verilog.f \
	-o sim_fetch_top

./obj_dir/sim_fetch_top | tee "$LOG"

if grep -q "^TEST PASSED$" "$LOG"; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1
